/* logic/fetch_pkg.sv */
// widths, opcodes, fetch entry struct and controller state type for the fetch frontend
`default_nettype none

package fetch_pkg;

  // ----------------------------------------------------------------------
  // widths and reset vector
  // ----------------------------------------------------------------------
  localparam int addr_w  = 32;
  localparam int instr_w = 32;

  // fetch starts here unless the top level overrides it
  localparam logic [addr_w-1:0] boot_addr_default = 32'h8000_0000;

  // ----------------------------------------------------------------------
  // major opcodes seen by the scan, bits [1:0] included
  // ----------------------------------------------------------------------
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;

  // control flow class of one fetched word
  typedef enum logic [1:0] {
    cf_none,
    cf_branch,
    cf_jump,
    cf_jalr
  } cf_e;

  // one queue entry toward decode, 97 bits
  typedef struct packed {
    logic [addr_w-1:0]  pc;
    logic [instr_w-1:0] instr;
    logic               pred_taken;
    // pc+4 when not taken
    logic [addr_w-1:0]  pred_target;
  } fetch_entry_t;

  // fetch controller states
  typedef enum logic [1:0] {
    st_boot,
    st_run,
    st_drop
  } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/fetch_ctrl_fsm.sv */
// fetch controller FSM for boot, running and dropping a stale memory response
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic imem_ready_i,
  input  logic imem_valid_i,
  input  logic has_room_i,
  input  logic pred_redirect_i,
  input  logic ext_redirect_i,
  output logic imem_req_o,
  output logic boot_load_o,
  output logic advance_o,
  output logic accept_rsp_o
);

  import fetch_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        req_accepted;
  logic        redirect;

  // ----------------------------------------------------------------------
  // outputs
  // ----------------------------------------------------------------------
  // no request in the boot cycle, the pc register is loaded then
  assign boot_load_o  = (state_q == st_boot);
  // new target may already go out while the stale response is dropped
  assign imem_req_o   = (state_q != st_boot) && has_room_i;
  assign req_accepted = imem_req_o && imem_ready_i;
  // pc moves on with every accepted request
  assign advance_o    = req_accepted;
  // the response arriving in st_drop belongs to the old path
  assign accept_rsp_o = imem_valid_i && (state_q == st_run);

  assign redirect = pred_redirect_i || ext_redirect_i;

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_boot: begin
        state_d = st_run;
      end
      st_run, st_drop: begin
        // a request accepted in a redirect cycle fetched the wrong address,
        // its response comes next cycle and must be thrown away
        if (redirect && req_accepted) begin
          state_d = st_drop;
        end else begin
          state_d = st_run;
        end
      end
      default: begin
        state_d = st_boot;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_boot;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
// next-PC register with redirect priority and prediction of the current response
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
  parameter logic [fetch_pkg::addr_w-1:0] boot_addr = fetch_pkg::boot_addr_default
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          boot_load_i,
  input  logic                          advance_i,
  input  logic                          rsp_valid_i,
  input  logic [fetch_pkg::addr_w-1:0]  rsp_pc_i,
  input  fetch_pkg::cf_e                cf_i,
  input  logic [fetch_pkg::addr_w-1:0]  imm_i,
  input  logic                          bht_valid_i,
  input  logic                          bht_taken_i,
  input  logic                          resolve_mispredict_i,
  input  logic [fetch_pkg::addr_w-1:0]  resolve_target_i,
  input  logic                          ex_valid_i,
  input  logic [fetch_pkg::addr_w-1:0]  trap_vector_i,
  output logic [fetch_pkg::addr_w-1:0]  fetch_addr_o,
  output logic                          pred_taken_o,
  output logic [fetch_pkg::addr_w-1:0]  pred_target_o,
  output logic                          pred_redirect_o,
  output logic                          ext_redirect_o
);

  import fetch_pkg::*;

  logic [addr_w-1:0] npc_q, npc_d;
  logic              branch_taken;

  // ----------------------------------------------------------------------
  // prediction for the word in the current response
  // ----------------------------------------------------------------------
  // counter decides when trained, else backward branches are taken
  assign branch_taken = bht_valid_i ? bht_taken_i : imm_i[addr_w-1];

  // jal always taken, jalr never predicted
  assign pred_taken_o = rsp_valid_i &&
                        ((cf_i == cf_jump) || ((cf_i == cf_branch) && branch_taken));
  assign pred_target_o = pred_taken_o ? (rsp_pc_i + imm_i) : (rsp_pc_i + addr_w'(4));

  assign pred_redirect_o = pred_taken_o;
  assign ext_redirect_o  = resolve_mispredict_i || ex_valid_i;

  // ----------------------------------------------------------------------
  // next pc, later assignments win
  // ----------------------------------------------------------------------
  always_comb begin
    npc_d = npc_q;
    if (advance_i) begin
      npc_d = npc_q + addr_w'(4);
    end
    if (pred_redirect_o) begin
      npc_d = pred_target_o;
    end
    if (resolve_mispredict_i) begin
      npc_d = resolve_target_i;
    end
    if (ex_valid_i) begin
      npc_d = trap_vector_i;
    end
    // first cycle out of reset
    if (boot_load_i) begin
      npc_d = boot_addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      npc_q <= '0;
    end else begin
      npc_q <= npc_d;
    end
  end

  assign fetch_addr_o = npc_q;

endmodule

`default_nettype wire

/* logic/branch_scan.sv */
// control flow class and sign-extended immediate of one fetched 32-bit word
`timescale 1ns/1ps
`default_nettype none

module branch_scan (
  input  logic [fetch_pkg::instr_w-1:0] instr_i,
  output fetch_pkg::cf_e                cf_o,
  output logic [fetch_pkg::addr_w-1:0]  imm_o
);

  import fetch_pkg::*;

  logic [6:0]        opcode;
  logic [addr_w-1:0] j_imm;
  logic [addr_w-1:0] b_imm;

  assign opcode = instr_i[6:0];

  // J-type with bit 0 always zero
  assign j_imm = {{(addr_w-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  // B-type with bit 0 always zero
  assign b_imm = {{(addr_w-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  always_comb begin
    cf_o  = cf_none;
    imm_o = '0;
    unique case (opcode)
      opcode_jal: begin
        cf_o  = cf_jump;
        imm_o = j_imm;
      end
      opcode_jalr: begin
        // target comes from a register and is never predicted
        cf_o  = cf_jalr;
      end
      opcode_branch: begin
        cf_o  = cf_branch;
        imm_o = b_imm;
      end
      default: begin
        // plain instruction so fetch goes on sequentially
        cf_o  = cf_none;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/bht.sv */
// branch history table of 2-bit saturating counters with lookup and update port
`timescale 1ns/1ps
`default_nettype none

module bht #(
  parameter int bht_entries = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [fetch_pkg::addr_w-1:0] lookup_pc_i,
  input  logic                         update_valid_i,
  input  logic [fetch_pkg::addr_w-1:0] update_pc_i,
  input  logic                         update_taken_i,
  output logic                         valid_o,
  output logic                         taken_o
);

  import fetch_pkg::*;

  // power of two, index taken above the word offset
  localparam int idx_w = $clog2(bht_entries);

  logic             valid_q [bht_entries];
  logic [1:0]       cnt_q   [bht_entries];
  logic [idx_w-1:0] lookup_idx;
  logic [idx_w-1:0] update_idx;

  assign lookup_idx = lookup_pc_i[idx_w+1:2];
  assign update_idx = update_pc_i[idx_w+1:2];

  // ----------------------------------------------------------------------
  // combinational lookup
  // ----------------------------------------------------------------------
  assign valid_o = valid_q[lookup_idx];
  // weakly or strongly taken
  assign taken_o = cnt_q[lookup_idx][1];

  // ----------------------------------------------------------------------
  // update from resolved branches
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < bht_entries; i++) begin
        valid_q[i] <= 1'b0;
        cnt_q[i]   <= 2'd0;
      end
    end else if (update_valid_i) begin
      if (!valid_q[update_idx]) begin
        // first outcome starts the counter weakly
        valid_q[update_idx] <= 1'b1;
        cnt_q[update_idx]   <= update_taken_i ? 2'd2 : 2'd1;
      end else if (update_taken_i) begin
        if (cnt_q[update_idx] != 2'd3) begin
          cnt_q[update_idx] <= cnt_q[update_idx] + 2'd1;
        end
      end else begin
        if (cnt_q[update_idx] != 2'd0) begin
          cnt_q[update_idx] <= cnt_q[update_idx] - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_fifo.sv */
// circular fetch entry queue toward decode with occupancy counter and flush
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t entry_i,
  input  logic                    ready_i,
  output logic                    valid_o,
  output fetch_pkg::fetch_entry_t entry_o,
  output logic                    has_room_o
);

  import fetch_pkg::*;

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  fetch_entry_t     mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign valid_o = (count_q != '0);
  assign entry_o = mem[rd_ptr_q];
  // one request in flight plus one arriving need two free slots
  assign has_room_o = (int'(count_q) <= fifo_depth - 2);

  assign do_pop  = valid_o && ready_i && !flush_i;
  assign do_push = push_i && !flush_i && (int'(count_q) < fifo_depth);

  // ----------------------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // everything queued belongs to the old path
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= entry_i;
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_frontend.sv */
// fetch frontend top level with controller, pc generation, scan, BHT and queue
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
  parameter int                           fifo_depth  = 4,
  parameter int                           bht_entries = 16,
  parameter logic [fetch_pkg::addr_w-1:0] boot_addr   = fetch_pkg::boot_addr_default
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // instruction memory
  output logic                          imem_req_o,
  output logic [fetch_pkg::addr_w-1:0]  imem_addr_o,
  input  logic                          imem_ready_i,
  input  logic                          imem_valid_i,
  input  logic [fetch_pkg::instr_w-1:0] imem_data_i,
  // decode
  output logic                          fetch_valid_o,
  output fetch_pkg::fetch_entry_t       fetch_entry_o,
  input  logic                          fetch_ready_i,
  // branch resolution
  input  logic                          resolve_valid_i,
  input  logic [fetch_pkg::addr_w-1:0]  resolve_pc_i,
  input  logic                          resolve_taken_i,
  input  logic                          resolve_mispredict_i,
  input  logic [fetch_pkg::addr_w-1:0]  resolve_target_i,
  input  logic                          resolve_is_branch_i,
  // trap
  input  logic                          ex_valid_i,
  input  logic [fetch_pkg::addr_w-1:0]  trap_vector_i
);

  import fetch_pkg::*;

  logic              has_room, pred_redirect, ext_redirect;
  logic              boot_load, advance, accept_rsp;
  logic              is_mispredict, bht_update;
  logic              bht_valid, bht_taken;
  logic              pred_taken;
  logic [addr_w-1:0] pred_target;
  logic [addr_w-1:0] rsp_pc_q;
  cf_e               cf;
  logic [addr_w-1:0] imm;
  fetch_entry_t      rsp_entry;

  assign is_mispredict = resolve_valid_i && resolve_mispredict_i;
  assign bht_update    = resolve_valid_i && resolve_is_branch_i;

  // ----------------------------------------------------------------------
  // address of the request in flight, the response comes one cycle later
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (advance) begin
      rsp_pc_q <= imem_addr_o;
    end
  end

  fetch_ctrl_fsm i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .imem_ready_i   (imem_ready_i),
    .imem_valid_i   (imem_valid_i),
    .has_room_i     (has_room),
    .pred_redirect_i(pred_redirect),
    .ext_redirect_i (ext_redirect),
    .imem_req_o     (imem_req_o),
    .boot_load_o    (boot_load),
    .advance_o      (advance),
    .accept_rsp_o   (accept_rsp)
  );

  branch_scan i_scan (
    .instr_i(imem_data_i),
    .cf_o   (cf),
    .imm_o  (imm)
  );

  bht #(
    .bht_entries(bht_entries)
  ) i_bht (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_pc_i   (rsp_pc_q),
    .update_valid_i(bht_update),
    .update_pc_i   (resolve_pc_i),
    .update_taken_i(resolve_taken_i),
    .valid_o       (bht_valid),
    .taken_o       (bht_taken)
  );

  pc_gen #(
    .boot_addr(boot_addr)
  ) i_pc_gen (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_load_i         (boot_load),
    .advance_i           (advance),
    .rsp_valid_i         (accept_rsp),
    .rsp_pc_i            (rsp_pc_q),
    .cf_i                (cf),
    .imm_i               (imm),
    .bht_valid_i         (bht_valid),
    .bht_taken_i         (bht_taken),
    .resolve_mispredict_i(is_mispredict),
    .resolve_target_i    (resolve_target_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i),
    .fetch_addr_o        (imem_addr_o),
    .pred_taken_o        (pred_taken),
    .pred_target_o       (pred_target),
    .pred_redirect_o     (pred_redirect),
    .ext_redirect_o      (ext_redirect)
  );

  // entry written on the edge the response arrives
  assign rsp_entry.pc          = rsp_pc_q;
  assign rsp_entry.instr       = imem_data_i;
  assign rsp_entry.pred_taken  = pred_taken;
  assign rsp_entry.pred_target = pred_target;

  fetch_fifo #(
    .fifo_depth(fifo_depth)
  ) i_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (ext_redirect),
    .push_i    (accept_rsp),
    .entry_i   (rsp_entry),
    .ready_i   (fetch_ready_i),
    .valid_o   (fetch_valid_o),
    .entry_o   (fetch_entry_o),
    .has_room_o(has_room)
  );

endmodule

`default_nettype wire

/* bench/imem_model.sv */
// instruction memory model with random ready and a response one cycle after acceptance
`timescale 1ns/1ps
`default_nettype none

module imem_model #(
  parameter int words = 1024
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        ready_o,
  output logic        valid_o,
  output logic [31:0] data_o
);

  // addi x0, x0, 0
  localparam logic [31:0] nop = 32'h0000_0013;

  logic [31:0] table_q [words];
  logic        pend;
  logic [31:0] pend_addr;
  integer      seed;

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return table_q[(addr >> 2) % words];
  endfunction

  task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
    table_q[(addr >> 2) % words] = word;
  endtask

  initial begin
    for (int i = 0; i < words; i++) begin
      table_q[i] = nop;
    end
    seed      = 32'h9c71fc69;
    ready_o   = 1'b0;
    valid_o   = 1'b0;
    data_o    = '0;
    pend      = 1'b0;
    pend_addr = '0;
  end

  // request and address are stable by mid cycle
  always @(negedge clk_i) begin
    pend      = rst_ni && req_i && ready_o;
    pend_addr = addr_i;
  end

  // answer in the cycle after the accepting edge, ready about 3 of 4 cycles
  always @(posedge clk_i) begin
    #2;
    valid_o = pend;
    data_o  = pend ? word_at(pend_addr) : '0;
    ready_o = ($random(seed) & 3) != 0;
  end

endmodule

`default_nettype wire

/* bench/tb_fetch_frontend.sv */
// clock, reset, stimulus, reference model and checks of the fetch frontend testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

  import fetch_pkg::*;

  localparam logic [31:0] boot       = 32'h8000_0000;
  localparam int          tab_words  = 1024;
  localparam int          wait_limit = 200;
  // word classes of the shadow table
  localparam int k_none   = 0;
  localparam int k_branch = 1;
  localparam int k_jal    = 2;
  localparam int k_jalr   = 3;

  logic         clk_i, rst_ni;
  logic         imem_req_o, imem_ready_i, imem_valid_i;
  logic [31:0]  imem_addr_o, imem_data_i;
  logic         fetch_valid_o, fetch_ready_i;
  fetch_entry_t fetch_entry_o;
  logic         resolve_valid_i, resolve_taken_i, resolve_mispredict_i, resolve_is_branch_i;
  logic [31:0]  resolve_pc_i, resolve_target_i;
  logic         ex_valid_i;
  logic [31:0]  trap_vector_i;

  integer       seed;
  int           errors, checks, xfer_cnt, tests_run, tests_failed, err_mark;
  string        test_name;
  logic [31:0]  exp_pc;
  fetch_entry_t exp_e;
  // shadow of each word class and of the BHT counters
  int           kind_tab [tab_words];
  logic [31:0]  off_tab  [tab_words];
  logic         sh_vld   [16];
  logic [1:0]   sh_cnt   [16];

  fetch_frontend #(
    .fifo_depth (4),
    .bht_entries(16),
    .boot_addr  (boot)
  ) uut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .imem_req_o          (imem_req_o),
    .imem_addr_o         (imem_addr_o),
    .imem_ready_i        (imem_ready_i),
    .imem_valid_i        (imem_valid_i),
    .imem_data_i         (imem_data_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_entry_o       (fetch_entry_o),
    .fetch_ready_i       (fetch_ready_i),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_pc_i        (resolve_pc_i),
    .resolve_taken_i     (resolve_taken_i),
    .resolve_mispredict_i(resolve_mispredict_i),
    .resolve_target_i    (resolve_target_i),
    .resolve_is_branch_i (resolve_is_branch_i),
    .ex_valid_i          (ex_valid_i),
    .trap_vector_i       (trap_vector_i)
  );

  imem_model #(.words(tab_words)) imem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (imem_req_o),
    .addr_i (imem_addr_o),
    .ready_o(imem_ready_i),
    .valid_o(imem_valid_i),
    .data_o (imem_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------
  // jal x1, off
  function automatic logic [31:0] enc_jal(input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, opcode_jal};
  endfunction

  // beq x10, x11, off
  function automatic logic [31:0] enc_branch(input logic [31:0] off);
    return {off[12], off[10:5], 5'd11, 5'd10, 3'b000, off[4:1], off[11], opcode_branch};
  endfunction

  // entry that decode should see for a given pc
  function automatic fetch_entry_t expected_entry(input logic [31:0] pc);
    fetch_entry_t e;
    int           i;
    logic [3:0]   b;
    logic         taken;
    i = (pc >> 2) % tab_words;
    b = pc[5:2];
    case (kind_tab[i])
      k_jal:    taken = 1'b1;
      // backward means taken unless the counter is trained
      k_branch: taken = sh_vld[b] ? (sh_cnt[b] >= 2'd2) : ($signed(off_tab[i]) < 0);
      default:  taken = 1'b0;
    endcase
    e.pc          = pc;
    e.instr       = imem.word_at(pc);
    e.pred_taken  = taken;
    e.pred_target = taken ? pc + off_tab[i] : pc + 32'd4;
    return e;
  endfunction

  task automatic report_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic put_word(input logic [31:0] addr, input logic [31:0] word, input int kind,
                          input logic [31:0] off);
    imem.load_word(addr, word);
    kind_tab[(addr >> 2) % tab_words] = kind;
    off_tab[(addr >> 2) % tab_words]  = off;
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, errors - err_mark);
    end
  endtask

  task automatic wait_xfers(input int n);
    int target;
    int cycles;
    target = xfer_cnt + n;
    cycles = 0;
    while (xfer_cnt < target && cycles < wait_limit) begin
      step();
      cycles++;
    end
    if (xfer_cnt < target) begin
      errors++;
      $display("timeout: only %0d of %0d entries reached decode in %0d cycles",
               n - (target - xfer_cnt), n, wait_limit);
    end
  endtask

  // decode stalls until the queue is full and nothing is in flight
  task automatic stall_until_idle();
    int quiet;
    int cycles;
    fetch_ready_i = 1'b0;
    quiet  = 0;
    cycles = 0;
    while (quiet < 2 && cycles < wait_limit) begin
      @(negedge clk_i);
      quiet = imem_req_o ? 0 : quiet + 1;
      cycles++;
    end
    if (quiet < 2) begin
      errors++;
      $display("timeout: fetch kept requesting although decode was stalled");
    end
    step();
  endtask

  // decode is not ready in the pulse cycle while the queue is flushed
  task automatic redirect(input logic mis, input logic trap, input logic [31:0] rtgt,
                          input logic [31:0] tvec);
    fetch_ready_i        = 1'b0;
    resolve_valid_i      = mis;
    resolve_mispredict_i = mis;
    resolve_target_i     = rtgt;
    ex_valid_i           = trap;
    trap_vector_i        = tvec;
    step();
    resolve_valid_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    ex_valid_i           = 1'b0;
    // trap vector beats a mispredict target
    exp_pc        = trap ? tvec : rtgt;
    fetch_ready_i = 1'b1;
  endtask

  task automatic train_branch(input logic [31:0] pc, input logic taken);
    logic [3:0] b;
    b = pc[5:2];
    resolve_valid_i     = 1'b1;
    resolve_is_branch_i = 1'b1;
    resolve_pc_i        = pc;
    resolve_taken_i     = taken;
    step();
    resolve_valid_i     = 1'b0;
    resolve_is_branch_i = 1'b0;
    // first outcome starts weak and later ones saturate
    if (!sh_vld[b]) begin
      sh_vld[b] = 1'b1;
      sh_cnt[b] = taken ? 2'd2 : 2'd1;
    end else if (taken && sh_cnt[b] != 2'd3) begin
      sh_cnt[b] = sh_cnt[b] + 2'd1;
    end else if (!taken && sh_cnt[b] != 2'd0) begin
      sh_cnt[b] = sh_cnt[b] - 2'd1;
    end
  endtask

  // long stall with a full queue followed by random decode ready
  task automatic stall_and_release(input int n);
    fetch_entry_t held;
    int           target;
    int           cycles;
    fetch_ready_i = 1'b0;
    held = '0;
    for (int i = 0; i < 40; i++) begin
      @(negedge clk_i);
      if (i == 19) begin
        held = fetch_entry_o;
      end
      if (i >= 20) begin
        checks += 3;
        assert (!imem_req_o) else report_value("request with full queue", imem_req_o, 0);
        assert (fetch_valid_o) else report_value("valid during stall", fetch_valid_o, 1);
        assert (fetch_entry_o == held) else report_value("held pc", fetch_entry_o.pc, held.pc);
      end
    end
    step();
    target = xfer_cnt + n;
    cycles = 0;
    while (xfer_cnt < target && cycles < wait_limit) begin
      fetch_ready_i = ($random(seed) & 1) != 0;
      step();
      cycles++;
    end
    fetch_ready_i = 1'b1;
    if (xfer_cnt < target) begin
      errors++;
      $display("timeout: entries stopped reaching decode after the stall");
    end
  endtask

  // ----------------------------------------------------------------------
  // decode port checker sampling at the falling edge where values are stable
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && fetch_valid_o && fetch_ready_i) begin
      exp_e  = expected_entry(exp_pc);
      checks += 4;
      assert (fetch_entry_o.pc == exp_e.pc) else report_value("pc", fetch_entry_o.pc, exp_e.pc);
      assert (fetch_entry_o.instr == exp_e.instr)
        else report_value("instr", fetch_entry_o.instr, exp_e.instr);
      assert (fetch_entry_o.pred_taken == exp_e.pred_taken)
        else report_value("pred_taken", fetch_entry_o.pred_taken, exp_e.pred_taken);
      assert (fetch_entry_o.pred_target == exp_e.pred_target)
        else report_value("pred_target", fetch_entry_o.pred_target, exp_e.pred_target);
      exp_pc = exp_e.pred_target;
      xfer_cnt++;
    end
  end

  initial begin
    #200000;
    $display("timeout: simulation did not reach its end");
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    seed                 = 32'h9c71fc69;
    rst_ni               = 1'b0;
    fetch_ready_i        = 1'b0;
    resolve_valid_i      = 1'b0;
    resolve_pc_i         = '0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_target_i     = '0;
    resolve_is_branch_i  = 1'b0;
    ex_valid_i           = 1'b0;
    trap_vector_i        = '0;
    errors       = 0;
    checks       = 0;
    xfer_cnt     = 0;
    tests_run    = 0;
    tests_failed = 0;
    exp_pc       = boot;
    for (int i = 0; i < tab_words; i++) begin
      kind_tab[i] = k_none;
      off_tab[i]  = '0;
    end
    for (int i = 0; i < 16; i++) begin
      sh_vld[i] = 1'b0;
      sh_cnt[i] = 2'd0;
    end

    begin_test("sequential fetch from boot address");
    repeat (16) begin
      @(negedge clk_i);
      checks++;
      assert (!imem_req_o && !fetch_valid_o)
        else report_value("req or valid in reset", {imem_req_o, fetch_valid_o}, 0);
    end
    @(posedge clk_i);
    #2;
    rst_ni        = 1'b1;
    fetch_ready_i = 1'b1;
    // the boot cycle has no request and the next one asks for the boot address
    @(negedge clk_i);
    checks++;
    assert (!imem_req_o && !fetch_valid_o)
      else report_value("req or valid in boot cycle", {imem_req_o, fetch_valid_o}, 0);
    @(negedge clk_i);
    checks += 2;
    assert (imem_req_o) else report_value("first request", imem_req_o, 1);
    assert (imem_addr_o == boot)
      else report_value("first request address", imem_addr_o, boot);
    wait_xfers(8);
    end_test();

    begin_test("jal taken, jalr not predicted");
    stall_until_idle();
    put_word(boot + 32'h108, enc_jal(32'h40), k_jal, 32'h40);
    // never reaches decode
    put_word(boot + 32'h10c, 32'h0010_0293, k_none, 0);
    put_word(boot + 32'h14c, 32'h0000_8067, k_jalr, 0);
    redirect(1'b0, 1'b1, '0, boot + 32'h100);
    wait_xfers(8);
    end_test();

    begin_test("static backward taken, forward not taken");
    stall_until_idle();
    put_word(boot + 32'h240, enc_branch(32'h40), k_branch, 32'h40);
    put_word(boot + 32'h248, enc_branch(-72), k_branch, -72);
    redirect(1'b0, 1'b1, '0, boot + 32'h240);
    wait_xfers(8);
    end_test();

    begin_test("trained counter predicts forward branch taken");
    stall_until_idle();
    put_word(boot + 32'h304, enc_branch(32'h20), k_branch, 32'h20);
    redirect(1'b0, 1'b1, '0, boot + 32'h300);
    wait_xfers(4);
    stall_until_idle();
    train_branch(boot + 32'h304, 1'b1);
    train_branch(boot + 32'h304, 1'b1);
    redirect(1'b0, 1'b1, '0, boot + 32'h300);
    wait_xfers(4);
    end_test();

    begin_test("mispredict and trap redirect, trap wins");
    wait_xfers(3);
    redirect(1'b1, 1'b0, boot + 32'h400, '0);
    wait_xfers(4);
    redirect(1'b0, 1'b1, '0, boot + 32'h480);
    wait_xfers(4);
    redirect(1'b1, 1'b1, boot + 32'h500, boot + 32'h580);
    wait_xfers(4);
    end_test();

    begin_test("decode back-pressure keeps order");
    stall_and_release(12);
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/fetch_pkg.sv
logic/fetch_ctrl_fsm.sv
logic/pc_gen.sv
logic/branch_scan.sv
logic/bht.sv
logic/fetch_fifo.sv
logic/fetch_frontend.sv
bench/imem_model.sv
bench/tb_fetch_frontend.sv
